//--- hw/emesh_config.svh
`ifndef EMESH_CONFIG_SVH
`define EMESH_CONFIG_SVH

// ######################################################################
// Emesh link geometry
// ######################################################################

`define EMESH_PW 104  // Full packet width
`define EMESH_AW 32   // dstaddr / srcaddr width
`define EMESH_DW 32   // Data word width

// ######################################################################
// Endpoint sizing
// ######################################################################

`define EMESH_MEM_WORDS 256                       // Local word memory depth
`define EMESH_WIDX_LSB  2                         // Byte offset bits dropped
`define EMESH_WIDX_W    $clog2(`EMESH_MEM_WORDS)  // Word index width, addr[9:2]
`define EMESH_RX_DEPTH  2                         // Input queue entries

`endif

//--- hw/emesh_pkg.sv
`include "emesh_config.svh"

package emesh_pkg;

  // Emesh packet, field order matches the link bit layout
  // Bit 0 is write, srcaddr sits on top
  typedef struct packed {
    logic [`EMESH_AW-1:0] srcaddr;   // [103:72]
    logic [`EMESH_DW-1:0] data;      // [71:40]
    logic [`EMESH_AW-1:0] dstaddr;   // [39:8]
    logic [4:0]           ctrlmode;  // [7:3]
    logic [1:0]           datamode;  // [2:1], carried only
    logic                 write;     // [0]
  } emesh_packet_t;

  // Memory opcode, follows the packet write bit
  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_t;

  // Decoded request from rx to the core
  typedef struct packed {
    mem_op_t                  op;
    logic [`EMESH_WIDX_W-1:0] widx;      // Word index into memory
    logic [`EMESH_DW-1:0]     wdata;
    logic [`EMESH_AW-1:0]     ret_addr;  // Requester srcaddr
    logic [`EMESH_AW-1:0]     req_addr;  // Original dstaddr
    logic [4:0]               ctrlmode;
    logic [1:0]               datamode;
  } mem_req_t;

  // Read result from the core to tx
  typedef struct packed {
    logic [`EMESH_DW-1:0] rdata;
    logic [`EMESH_AW-1:0] ret_addr;
    logic [`EMESH_AW-1:0] req_addr;
    logic [4:0]           ctrlmode;
    logic [1:0]           datamode;
  } mem_rsp_t;

  typedef enum logic {
    tx_idle = 1'b0,  // Nothing on the link
    tx_hold = 1'b1   // access_out high, packet held
  } tx_state_t;

endpackage

//--- hw/emesh_rx.sv
`include "emesh_config.svh"

module emesh_rx import emesh_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          access_in,
  input  emesh_packet_t packet_in,
  output logic          wait_out,
  output logic          req_valid,
  output mem_req_t      req,
  input  logic          core_stall
);

  localparam int DEPTH = `EMESH_RX_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [`EMESH_PW-1:0] q_mem [DEPTH];  // Raw packet slots
  logic [PTR_W-1:0]     wr_ptr;
  logic [PTR_W-1:0]     rd_ptr;
  logic [CNT_W-1:0]     count;         // Occupied entries
  logic                 push;
  logic                 pop;
  emesh_packet_t        head;

  // ######################################################################
  // Queue control
  // ######################################################################

  assign push      = access_in && !wait_out;   // Link handshake
  assign pop       = req_valid && !core_stall; // Core takes head
  assign wait_out  = (count == CNT_W'(DEPTH)); // Full, hold the sender
  assign req_valid = (count != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({push, pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // Idle or simultaneous
      endcase
    end
  end

  // Storage only, pointers qualify it
  always_ff @(posedge clk) begin
    if (push) begin
      q_mem[wr_ptr] <= packet_in;
    end
  end

  // ######################################################################
  // Head decode
  // ######################################################################

  assign head = emesh_packet_t'(q_mem[rd_ptr]);

  always_comb begin
    req.op       = head.write ? op_write : op_read;
    req.widx     = head.dstaddr[`EMESH_WIDX_LSB +: `EMESH_WIDX_W]; // Upper bits ignored
    req.wdata    = head.data;
    req.ret_addr = head.srcaddr;  // Where a read answer goes
    req.req_addr = head.dstaddr;
    req.ctrlmode = head.ctrlmode;
    req.datamode = head.datamode;
  end

endmodule

//--- hw/emesh_mem_core.sv
`include "emesh_config.svh"

module emesh_mem_core import emesh_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req_valid,
  input  mem_req_t req,
  output logic     core_stall,
  output logic     rsp_valid,
  output mem_rsp_t rsp,
  input  logic     tx_busy
);

  logic [`EMESH_DW-1:0] mem [`EMESH_MEM_WORDS];  // Word memory, contents unknown at start
  logic                 take;
  logic                 take_rd;

  // ######################################################################
  // Flow control
  // ######################################################################

  // Stall only while a result is parked and tx cannot take it
  assign core_stall = rsp_valid && tx_busy;
  assign take       = req_valid && !core_stall;
  assign take_rd    = take && (req.op == op_read);

  // Result valid drops once tx has taken it and nothing new arrives
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
    end else if (!core_stall) begin
      rsp_valid <= take_rd;
    end
  end

  // ######################################################################
  // Memory access
  // ######################################################################

  // Write lands on the same edge the request is taken
  always_ff @(posedge clk) begin
    if (take) begin
      case (req.op)
        op_write: begin
          mem[req.widx] <= req.wdata;  // No response for writes
        end
        op_read: begin
          // Synchronous read, sees a write from the previous edge
          rsp.rdata    <= mem[req.widx];
          rsp.ret_addr <= req.ret_addr;
          rsp.req_addr <= req.req_addr;
          rsp.ctrlmode <= req.ctrlmode;
          rsp.datamode <= req.datamode;
        end
        default: begin
        end
      endcase
    end
  end

endmodule

//--- hw/emesh_tx.sv
`include "emesh_config.svh"

module emesh_tx import emesh_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rsp_valid,
  input  mem_rsp_t      rsp,
  output logic          tx_busy,
  output logic          access_out,
  output emesh_packet_t packet_out,
  input  logic          wait_in
);

  tx_state_t state;
  tx_state_t state_nxt;
  logic      load;

  // Busy only when the held packet is blocked, so a handoff
  // and a new load share one edge
  assign tx_busy    = (state == tx_hold) && wait_in;
  assign load       = rsp_valid && !tx_busy;
  assign access_out = (state == tx_hold);

  // ######################################################################
  // Output FSM
  // ######################################################################

  always_comb begin
    state_nxt = state;
    case (state)
      tx_idle: begin
        if (rsp_valid) begin
          state_nxt = tx_hold;
        end
      end
      tx_hold: begin
        if (!wait_in && !rsp_valid) begin
          state_nxt = tx_idle;  // Packet gone, nothing behind it
        end
      end
      default: state_nxt = tx_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= tx_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // Response packet, addresses swapped back to the requester
  always_ff @(posedge clk) begin
    if (load) begin
      packet_out.write    <= 1'b1;
      packet_out.datamode <= rsp.datamode;
      packet_out.ctrlmode <= rsp.ctrlmode;
      packet_out.dstaddr  <= rsp.ret_addr;
      packet_out.data     <= rsp.rdata;
      packet_out.srcaddr  <= rsp.req_addr;
    end
  end

endmodule

//--- hw/emesh_endpoint.sv
`include "emesh_config.svh"

module emesh_endpoint import emesh_pkg::*; (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          access_in,
  input  emesh_packet_t packet_in,
  output logic          wait_out,
  output logic          access_out,
  output emesh_packet_t packet_out,
  input  logic          wait_in
);

  // rx -> core
  logic     req_valid;
  mem_req_t req;
  logic     core_stall;
  // core -> tx
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     tx_busy;

  // ######################################################################
  // Pipeline, input queue -> memory -> output register
  // ######################################################################

  emesh_rx u_rx (
    .clk        (clk),
    .rst_n      (rst_n),
    .access_in  (access_in),
    .packet_in  (packet_in),
    .wait_out   (wait_out),
    .req_valid  (req_valid),
    .req        (req),
    .core_stall (core_stall)
  );

  emesh_mem_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req        (req),
    .core_stall (core_stall),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .tx_busy    (tx_busy)
  );

  emesh_tx u_tx (
    .clk        (clk),
    .rst_n      (rst_n),
    .rsp_valid  (rsp_valid),
    .rsp        (rsp),
    .tx_busy    (tx_busy),
    .access_out (access_out),
    .packet_out (packet_out),
    .wait_in    (wait_in)
  );

endmodule

//--- verification/dv_assertions.sv
`include "emesh_config.svh"

module dv_assertions import emesh_pkg::*; (
  input logic          clk,
  input logic          rst_n,
  input logic          access_in,
  input logic          wait_out,
  input logic          req_valid,
  input logic          core_stall,
  input logic          access_out,
  input emesh_packet_t packet_out,
  input logic          wait_in
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int OCC_W = $clog2(`EMESH_RX_DEPTH + 1);

  logic [OCC_W-1:0] occ;  // Packets off the link, not yet taken by the core

  // Own rx occupancy, counted from the link and core handshakes
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      occ <= '0;
    end else begin
      occ <= occ + OCC_W'(access_in && !wait_out) - OCC_W'(req_valid && !core_stall);
    end
  end

  // Outputs quiet once reset has been seen for an edge
  a_reset_quiet: assert property (@(posedge clk)
    (!rst_n && !$past(rst_n)) |-> (!wait_out && !access_out))
    else $error("outputs active during reset");

  // Held response stays put while the receiver waits
  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (access_out && wait_in) |=> (access_out && $stable(packet_out)))
    else $error("packet_out changed while wait_in high");

  a_wait_full: assert property (@(posedge clk) disable iff (!rst_n)
    (occ < OCC_W'(`EMESH_RX_DEPTH)) |-> !wait_out)  // Only a full queue pushes back
    else $error("wait_out high with rx queue not full");

endmodule

bind emesh_endpoint dv_assertions u_asrt (
  .clk        (clk),
  .rst_n      (rst_n),
  .access_in  (access_in),
  .wait_out   (wait_out),
  .req_valid  (req_valid),
  .core_stall (core_stall),
  .access_out (access_out),
  .packet_out (packet_out),
  .wait_in    (wait_in)
);

//--- verification/dv_top.sv
module dv_top import emesh_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_NS      = 8;
  localparam int ISO_TXN     = 6;   // Isolated reads, latency checked
  localparam int STREAK_TXN  = 18;  // From here on, no gaps and long waits
  localparam int READ_DELAY  = 3 * CLK_NS;  // Accept edge to first edge seeing access_out

  logic          clk = 1'b0;
  logic          rst_n;
  logic          access_in;
  emesh_packet_t packet_in;
  logic          wait_out;
  logic          access_out;
  emesh_packet_t packet_out;
  logic          wait_in;

  // Transactions from the data file
  logic          txn_op[$];
  logic [31:0]   txn_addr[$];
  logic [31:0]   txn_data[$];
  logic [31:0]   txn_exp[$];
  // Pending read answers, in request order
  emesh_packet_t exp_q[$];
  time           exp_time[$];
  logic          exp_iso[$];

  int            n_reads   = 0;
  int            rsp_count = 0;
  int            wait_seen = 0;
  int            phase     = 0;  // 0 isolated, 1 random, 2 streaks
  logic          loaded    = 1'b0;
  logic          prev_access = 1'b0;

  emesh_endpoint DUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .access_in  (access_in),
    .packet_in  (packet_in),
    .wait_out   (wait_out),
    .access_out (access_out),
    .packet_out (packet_out),
    .wait_in    (wait_in)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // ######################################################################
  // Helpers
  // ######################################################################

  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);  // Galois, taps 16,14,13,11
  endfunction

  // One LFSR step per bit taken
  task automatic draw(inout logic [15:0] st, input int n, output logic [31:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      st = lfsr_next(st);
      v  = {v[30:0], st[0]};
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("mismatch at %0d ns: %s got %h expected %h", $time, name, got, exp);
      abort_run("value check failed");
    end
  endtask

  // ######################################################################
  // Back-pressure and response monitor
  // ######################################################################

  always @(posedge clk) begin : wait_gen
    logic [15:0] st;
    logic [31:0] r;
    int          ph;
    if ($time < CLK_NS) st = 16'd57056;  // Seed on the first edge
    ph = phase;  // Taken at the edge, stimulus moves it 1 ns later
    #1;
    case (ph)
      1: begin
        draw(st, 2, r);
        wait_in = &r[1:0];  // 25 % busy
      end
      2: begin
        draw(st, 3, r);
        wait_in = |r[2:0];  // Long streaks
      end
      default: wait_in = 1'b0;
    endcase
  end

  // Mid-cycle sample, outputs settled since the last edge
  always @(negedge clk) begin : monitor
    emesh_packet_t e;
    if (rst_n) begin
      if (wait_out && phase == 2) wait_seen++;
      if (access_out && !prev_access && exp_iso.size() > 0 && exp_iso[0]) begin
        // Next edge is where the link first sees access_out high
        check_value("access_out delay", 32'(($time + CLK_NS / 2) - exp_time[0]),
                    32'(READ_DELAY));
      end
      if (access_out && !wait_in) begin
        if (exp_q.size() == 0) abort_run("response packet with no pending read");
        e = exp_q.pop_front();
        void'(exp_time.pop_front());
        void'(exp_iso.pop_front());
        check_value("packet_out.write", 32'(packet_out.write), 32'(e.write));
        check_value("packet_out.data", packet_out.data, e.data);
        check_value("packet_out.dstaddr", packet_out.dstaddr, e.dstaddr);
        check_value("packet_out.srcaddr", packet_out.srcaddr, e.srcaddr);
        check_value("packet_out.ctrlmode", 32'(packet_out.ctrlmode), 32'(e.ctrlmode));
        check_value("packet_out.datamode", 32'(packet_out.datamode), 32'(e.datamode));
        rsp_count++;
      end
    end
    prev_access = access_out;
  end

  initial begin : watchdog
    int limit_ns;
    wait (loaded);
    limit_ns = (txn_op.size() * 20 + 200) * CLK_NS;
    #(limit_ns);
    $display("timeout, responses missing: %0d of %0d received", rsp_count, n_reads);
    abort_run("watchdog expired");
  end

  // ######################################################################
  // Stimulus
  // ######################################################################

  initial begin : main
    int            fd;
    int            gap;
    string         line;
    logic [31:0]   f_op;
    logic [31:0]   f_addr;
    logic [31:0]   f_data;
    logic [31:0]   f_exp;
    logic [31:0]   r;
    logic [15:0]   st;
    logic          accepted;
    emesh_packet_t pkt;
    emesh_packet_t e;

    rst_n     = 1'b0;
    access_in = 1'b0;
    packet_in = '0;
    wait_in   = 1'b0;
    st        = 16'd57056;

    fd = $fopen("verification/emesh_testdata.txt", "r");
    if (fd == 0) abort_run("cannot open verification/emesh_testdata.txt");
    while ($fgets(line, fd) != 0) begin
      if ($sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp) == 4) begin  // Comments fail
        txn_op.push_back(f_op[0]);
        txn_addr.push_back(f_addr);
        txn_data.push_back(f_data);
        txn_exp.push_back(f_exp);
        if (!f_op[0]) n_reads++;
      end
    end
    $fclose(fd);
    loaded = 1'b1;

    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;

    for (int i = 0; i < txn_op.size(); i++) begin
      phase = (i < ISO_TXN) ? 0 : (i < STREAK_TXN) ? 1 : 2;
      if (i < ISO_TXN) begin
        gap = 8;  // Pipeline drains between requests
      end else if (i < STREAK_TXN) begin
        draw(st, 2, r);
        gap = int'(r[1:0]);
      end else begin
        gap = 0;
      end
      if (gap > 0) begin
        repeat (gap) @(posedge clk);
        #1;
      end
      draw(st, 32, r);
      pkt.srcaddr = r;
      draw(st, 5, r);
      pkt.ctrlmode = r[4:0];
      pkt.datamode = 2'(i);
      pkt.write    = txn_op[i];
      pkt.dstaddr  = txn_addr[i];
      pkt.data     = txn_data[i];
      access_in    = 1'b1;
      packet_in    = pkt;
      accepted     = 1'b0;
      while (!accepted) begin  // Held until wait_out is low at an edge
        @(negedge clk);
        accepted = !wait_out;
        @(posedge clk);
      end
      if (!pkt.write) begin
        e.write    = 1'b1;
        e.datamode = pkt.datamode;
        e.ctrlmode = pkt.ctrlmode;
        e.dstaddr  = pkt.srcaddr;  // Answer goes back to the requester
        e.srcaddr  = pkt.dstaddr;
        e.data     = txn_exp[i];
        exp_q.push_back(e);
        exp_time.push_back($time);
        exp_iso.push_back(phase == 0);
      end
      #1 access_in = 1'b0;
    end

    wait (rsp_count == n_reads);
    repeat (20) @(posedge clk);  // Catch any extra response

    if (wait_seen > 0) begin
      $display("sim passed");
      $finish;
    end else begin
      abort_run("wait_out never rose during the streak phase");
    end
  end

endmodule

//--- sim.f
+incdir+hw
hw/emesh_pkg.sv
hw/emesh_rx.sv
hw/emesh_mem_core.sv
hw/emesh_tx.sv
hw/emesh_endpoint.sv
verification/dv_assertions.sv
verification/dv_top.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the emesh endpoint testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module dv_top \
  -Mdir obj_dir -o dv_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/dv_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "sim failed" "$LOG"; then
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "sim passed" "$LOG"; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0

//--- verification/emesh_testdata.txt
# op(1 write, 0 read) dstaddr data expected_read_word
# reads use word index addr[9:2], upper address bits alias
1 00000000 11111111 00000000
0 00000000 00000000 11111111
1 00000004 a5a5a5a5 00000000
0 00000004 00000000 a5a5a5a5
1 00000400 cafef00d 00000000
0 00000000 00000000 cafef00d
1 00000008 01234567 00000000
1 0000000c 89abcdef 00000000
0 00000008 00000000 01234567
0 0000000c 00000000 89abcdef
1 000003fc deadbeef 00000000
0 000003fc 00000000 deadbeef
1 00000008 76543210 00000000
0 00000008 00000000 76543210
0 00000004 00000000 a5a5a5a5
1 00000010 0badcafe 00000000
0 00010010 00000000 0badcafe
0 00000000 00000000 cafef00d
1 00000020 aaaa0001 00000000
1 00000024 aaaa0002 00000000
1 00000028 aaaa0003 00000000
0 00000020 00000000 aaaa0001
0 00000024 00000000 aaaa0002
0 00000028 00000000 aaaa0003
0 000003fc 00000000 deadbeef
0 00000010 00000000 0badcafe
1 00000020 bbbb0004 00000000
0 00000020 00000000 bbbb0004
0 0000000c 00000000 89abcdef
0 00000004 00000000 a5a5a5a5
